// ==== tb/mips_stimulus.hex ====
// words 0-29: data memory image at 0x00-0x74, loaded into r2-r31
// words 30-43: expected sw data at 0x100-0x134 (r17-r30), word 44: expected r2 at halt
3c1d0f21
8e4a7b02
12345678
5a5a0303
5a5a0303
0badf00d
7e11a906
c0ffee07
13572468
2468ace9
fedcba0a
0000000b
ffffff0c
80000000
7fffffff
a1b2c3d4
600df00d
11112222
33334444
55556666
77778888
9999aaaa
bbbbcccc
ddddeeee
0f0f0f0f
f0f0f0f0
01020304
05060708
deadbeef
4d495053
a1b2c3d4
600df00d
11112222
33334444
55556666
77778888
9999aaaa
bbbbcccc
ddddeeee
0f0f0f0f
f0f0f0f0
01020304
05060708
deadbeef
00000000

// ==== list.f ====
common/mips_pkg.sv
rtl/mips_iram.sv
cpu/mips_regfile.sv
cpu/mips_cpu.sv
rtl/mips_system.sv
tb/tb_clock.sv
tb/mips_properties.sv
tb/mips_tb.sv

// ==== Makefile ====
# Verilator build and run of the mips testbench

SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vmips_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module mips_tb -f list.f

# pass only if the log holds the pass line
run: obj_dir/Vmips_tb
	./obj_dir/Vmips_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/mips_tb.sv ====
`timescale 1ns/1ps

// testbench top: data memory model, store checks, halt checks
module mips_tb;

    localparam int clk_period_ns    = 100;
    localparam int instr_limit      = 200;
    localparam int cycles_per_instr = 8;
    localparam int watchdog_ns      = instr_limit * cycles_per_instr * clk_period_ns;

    // stimulus layout: 30 load words, 14 store words, final r2
    localparam int n_loads  = 30;
    localparam int n_stores = 14;

    logic               clk;
    logic               rst_n;
    logic               mem_valid;
    logic               mem_ready = 1'b0;
    mips_pkg::mem_req_t mem_req;
    logic [31:0]        mem_rdata = 32'h0;
    logic               halted;
    logic [31:0]        register_v0;

    logic [31:0] stim [0:n_loads+n_stores];
    logic [31:0] dmem [0:255];
    logic [31:0] lcg_state = 32'h6602;
    int          read_count = 0;
    int          write_count = 0;

    tb_clock #(
        .period_ns    (clk_period_ns),
        .reset_cycles (8)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mips_system #(
        .iram_words (4096)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .halted      (halted),
        .register_v0 (register_v0)
    );

    // numerical recipes lcg constants
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // background word, unique per byte address
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hA5000000 | 32'(idx * 4);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    // one completed bus transfer against the expected order
    task automatic check_transfer(input mips_pkg::mem_req_t req);
        if (req.write) begin
            if (req.addr < 32'h100 || req.addr > 32'h134) begin
                fail_run($sformatf("store to 0x%h is outside the window 0x100 to 0x134",
                                   req.addr));
            end
            if (write_count >= n_stores) begin
                fail_run("the CPU issued more than 14 stores");
            end
            check_value("mem_req.addr", req.addr, 32'h100 + 32'(4 * write_count));
            check_value("mem_req.wdata", req.wdata, stim[n_loads + write_count]);
            dmem[req.addr[9:2]] = req.wdata;
            write_count++;
        end else begin
            if (write_count != 0) begin
                fail_run("a load reached the bus after the stores had begun");
            end
            if (read_count >= n_loads) begin
                fail_run("the CPU issued more than 30 loads");
            end
            // ascending, each word once
            check_value("mem_req.addr", req.addr, 32'(4 * read_count));
            read_count++;
        end
    endtask

    // data memory with 0 to 3 random wait cycles per request
    initial begin
        int wait_left;
        bit pending;
        wait_left = 0;
        pending = 1'b0;
        $readmemh("tb/mips_stimulus.hex", stim);
        for (int k = 0; k < 256; k++) begin
            dmem[k] = fill_word(k);
        end
        for (int k = 0; k < n_loads; k++) begin
            dmem[k] = stim[k];
        end
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                mem_ready <= 1'b0;
                pending = 1'b0;
            end else if (mem_valid && mem_ready) begin
                // transfer completes on this edge
                check_transfer(mem_req);
                mem_ready <= 1'b0;
                pending = 1'b0;
            end else if (mem_valid) begin
                if (!pending) begin
                    lcg_state = lcg_step(lcg_state);
                    wait_left = int'(lcg_state[31:30]);
                    pending = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_ready <= 1'b1;
                    mem_rdata <= dmem[mem_req.addr[9:2]];
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // main sequence: run to halt, then final checks
    initial begin
        wait (rst_n === 1'b1);
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        // halted must hold once set
        repeat (8) begin
            @(posedge clk);
            if (halted !== 1'b1) begin
                fail_run("halted dropped after the CPU had stopped");
            end
        end
        check_value("load count", 32'(read_count), 32'(n_loads));
        check_value("store count", 32'(write_count), 32'(n_stores));
        check_value("register_v0", register_v0, stim[n_loads + n_stores]);
        if (u_dut.u_cpu.u_props.failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run($sformatf("%0d bus or halt protocol assertion(s) failed",
                               u_dut.u_cpu.u_props.failures));
        end
    end

    // stop at the first failed bus or halt property
    initial begin
        wait (u_dut.u_cpu.u_props.failures != 0);
        fail_run("a bus or halt protocol assertion failed");
    end

    // upper bound on run length, reset included
    initial begin
        #(watchdog_ns);
        fail_run("watchdog expired before the CPU halted");
    end

endmodule

// ==== tb/mips_properties.sv ====
`timescale 1ns/1ps

// data bus and halt protocol checks on the core
module mips_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               mem_valid,
    input logic               mem_ready,
    input mips_pkg::mem_req_t mem_req,
    input logic               halted
);

    // count of failed assertions, read by the testbench top
    int failures = 0;

    // stalled request keeps address, data and direction
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> $stable(mem_req))
    else begin
        failures++;
        $error("mem_req changed while the bus was stalled");
    end

    valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid)
    else begin
        failures++;
        $error("mem_valid dropped before mem_ready");
    end

    // no bus traffic once stopped
    quiet_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !mem_valid)
    else begin
        failures++;
        $error("mem_valid high while halted");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
    else begin
        failures++;
        $error("halted fell without a reset");
    end

endmodule

bind mips_cpu mips_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_req   (mem_req),
    .halted    (halted)
);

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

// free running clock and power-on reset for the testbench
module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // reset low for a whole number of cycles, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== rtl/mips_system.sv ====
`timescale 1ns/1ps

// top level: core plus boot rom, data bus left to the outside
module mips_system #(
    parameter int iram_words = 4096
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               mem_valid,
    input  logic               mem_ready,
    output mips_pkg::mem_req_t mem_req,
    input  logic [31:0]        mem_rdata,
    output logic               halted,
    output logic [31:0]        register_v0
);

    // instruction fetch path, no handshake
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;

    mips_cpu u_cpu (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .mem_valid      (mem_valid),
        .mem_ready      (mem_ready),
        .mem_req        (mem_req),
        .mem_rdata      (mem_rdata),
        .halted         (halted),
        .register_v0    (register_v0)
    );

    mips_iram #(
        .iram_words (iram_words)
    ) u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

endmodule

// ==== cpu/mips_cpu.sv ====
`timescale 1ns/1ps

// multicycle mips core: fetch, decode, execute, memory, writeback
module mips_cpu (
    input  logic               clk,
    input  logic               rst_n,
    output logic [31:0]        instr_address,
    input  logic [31:0]        instr_readdata,
    output logic               mem_valid,
    input  logic               mem_ready,
    output mips_pkg::mem_req_t mem_req,
    input  logic [31:0]        mem_rdata,
    output logic               halted,
    output logic [31:0]        register_v0
);

    mips_pkg::cpu_state_e state;
    mips_pkg::cpu_state_e state_next;

    // pc is the instruction in flight, npc the one after it
    // keeping both gives the single branch delay slot
    logic [31:0] pc;
    logic [31:0] npc;

    // payload registers between states
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_out;
    logic [31:0] mdr;

    // decoded fields
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    logic [31:0]       imm_sext;
    logic [31:0]       br_offset;
    logic              is_lw;
    logic              is_sw;
    logic              is_beq;
    logic              is_addiu;
    logic              is_jr;
    logic              jump_to_zero;
    mips_pkg::cpu_state_e end_state;

    // register file hookup
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [31:0] wr_data;

    assign opcode    = mips_pkg::opcode_e'(ir[31:26]);
    assign funct     = mips_pkg::funct_e'(ir[5:0]);
    assign imm_sext  = {{16{ir[15]}}, ir[15:0]};
    assign br_offset = {imm_sext[29:0], 2'b00};

    assign is_lw    = (opcode == mips_pkg::op_lw);
    assign is_sw    = (opcode == mips_pkg::op_sw);
    assign is_beq   = (opcode == mips_pkg::op_beq);
    assign is_addiu = (opcode == mips_pkg::op_addiu);
    // sll 0 and unknown encodings fall through as nop
    assign is_jr    = (opcode == mips_pkg::op_special) && (funct == mips_pkg::fn_jr);

    // address of the next fetch once this instruction retires
    // in execute the pc has not yet taken npc
    assign jump_to_zero = (state == mips_pkg::st_execute) ? (npc == 32'h0) : (pc == 32'h0);
    assign end_state    = jump_to_zero ? mips_pkg::st_halted : mips_pkg::st_fetch;

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::st_fetch: state_next = mips_pkg::st_decode;
            mips_pkg::st_decode: state_next = mips_pkg::st_execute;
            mips_pkg::st_execute: begin
                if (is_lw || is_sw) begin
                    state_next = mips_pkg::st_memory;
                end else if (is_addiu) begin
                    state_next = mips_pkg::st_writeback;
                end else begin
                    state_next = end_state;
                end
            end
            mips_pkg::st_memory: begin
                // wait here for as long as the bus stalls
                if (mem_ready) begin
                    state_next = is_lw ? mips_pkg::st_writeback : end_state;
                end
            end
            mips_pkg::st_writeback: state_next = end_state;
            mips_pkg::st_halted: state_next = mips_pkg::st_halted;
            default: state_next = mips_pkg::st_fetch;
        endcase
    end

    // control state: fsm and the two program counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mips_pkg::st_fetch;
            pc    <= mips_pkg::boot_addr;
            npc   <= mips_pkg::boot_addr + mips_pkg::instr_bytes;
        end else begin
            state <= state_next;
            if (state == mips_pkg::st_execute) begin
                // the delay slot always runs next
                pc <= npc;
                if (is_beq && a == b) begin
                    npc <= npc + br_offset;
                end else if (is_jr) begin
                    npc <= a;
                end else begin
                    npc <= npc + mips_pkg::instr_bytes;
                end
            end
        end
    end

    // datapath payload
    always_ff @(posedge clk) begin
        if (state == mips_pkg::st_fetch) begin
            ir <= instr_readdata;
        end
        if (state == mips_pkg::st_decode) begin
            a <= rs_data;
            b <= rt_data;
        end
        // one adder serves addiu and the lw/sw address
        if (state == mips_pkg::st_execute) begin
            alu_out <= a + imm_sext;
        end
        if (state == mips_pkg::st_memory && mem_ready) begin
            mdr <= mem_rdata;
        end
    end

    assign instr_address = pc;

    // bus request comes from registers, so it is stable across wait cycles
    assign mem_valid     = (state == mips_pkg::st_memory);
    assign mem_req.addr  = {alu_out[31:2], 2'b00};
    assign mem_req.wdata = b;
    assign mem_req.write = is_sw;

    // writeback to rt for lw and addiu
    assign wr_en   = (state == mips_pkg::st_writeback);
    assign wr_data = is_lw ? mdr : alu_out;

    assign halted = (state == mips_pkg::st_halted);

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (ir[20:16]),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

endmodule

// ==== cpu/mips_regfile.sv ====
`timescale 1ns/1ps

// 32 x 32 register file, r0 reads as zero
module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    // r1 .. r31 only, r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= 32'h0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // two combinational read ports
    assign rs_data = (rs_addr == 5'd0) ? 32'h0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0 : regs[rt_addr];

    // v0 is r2, exported for status
    assign v0 = regs[2];

endmodule

// ==== rtl/mips_iram.sv ====
`timescale 1ns/1ps

// boot rom holding the built-in program, read combinationally
module mips_iram #(
    parameter int iram_words = 4096
) (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    logic [31:0] rom [0:iram_words-1];

    // byte offset inside the rom window
    logic [31:0] offset;
    // word index, wrapped to the rom depth
    logic [31:0] word_idx;

    // i-type word: opcode, rs, rt, 16 bit immediate
    function automatic logic [31:0] i_type(
        input mips_pkg::opcode_e op,
        input logic [4:0]        rs,
        input logic [4:0]        rt,
        input logic [15:0]       imm
    );
        return {op, rs, rt, imm};
    endfunction

    // r-type word: special opcode with rs, rt, rd, shamt and funct
    function automatic logic [31:0] r_type(
        input logic [4:0]       rs,
        input logic [4:0]       rt,
        input logic [4:0]       rd,
        input logic [4:0]       shamt,
        input mips_pkg::funct_e fn
    );
        return {mips_pkg::op_special, rs, rt, rd, shamt, fn};
    endfunction

    initial begin
        int w;
        w = 0;
        // unused words decode as nop
        for (int k = 0; k < iram_words; k++) begin
            rom[k] = 32'h0;
        end

        // lw ri, 4*(i-2)(r0) for r2 .. r31
        for (int i = 2; i < 32; i++) begin
            rom[w] = i_type(mips_pkg::op_lw, 5'd0, 5'(i), 16'((i - 2) * 4));
            w++;
        end

        // beq ri, ri+1, 2 then a nop in the delay slot
        // a taken branch skips the next beq and lands on its nop
        for (int i = 2; i < 31; i++) begin
            rom[w] = i_type(mips_pkg::op_beq, 5'(i), 5'(i + 1), 16'd2);
            w++;
            rom[w] = r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_sll);
            w++;
        end

        // sw r17 .. r30 to 0x100 .. 0x134
        for (int i = 17; i < 31; i++) begin
            rom[w] = i_type(mips_pkg::op_sw, 5'd0, 5'(i), 16'(16'h100 + (i - 17) * 4));
            w++;
        end

        // jr r0 ends the program after its delay slot
        rom[w] = r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr);
        w++;

        // delay slot: addiu r2, r0, 0 clears v0
        rom[w] = i_type(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0);
        w++;
    end

    // address taken modulo the boot vector, then to a word index
    assign offset   = instr_address % mips_pkg::boot_addr;
    assign word_idx = (offset >> 2) % iram_words;

    always_comb begin
        instr_readdata = rom[word_idx];
    end

endmodule

// ==== common/mips_pkg.sv ====
// shared types and constants for the multicycle mips core
package mips_pkg;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_beq     = 6'b000100,
        op_addiu   = 6'b001001,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_e;

    // function field of special instructions, bits 5:0
    typedef enum logic [5:0] {
        // sll with zero shift and zero registers is the canonical nop
        fn_sll = 6'b000000,
        fn_jr  = 6'b001000
    } funct_e;

    // one state per cycle of the multicycle sequence
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        // terminal state after a jump to address zero
        st_halted
    } cpu_state_e;

    // data bus request, held stable while the bus stalls
    typedef struct packed {
        // word aligned byte address
        logic [31:0] addr;
        // store data, ignored on reads
        logic [31:0] wdata;
        // high for sw, low for lw
        logic        write;
    } mem_req_t;

    // reset vector, also the base of the instruction rom window
    localparam logic [31:0] boot_addr = 32'hBFC00000;

    // word step between consecutive instructions
    localparam logic [31:0] instr_bytes = 32'd4;

endpackage
